// File: vlog.f
+incdir+design
+incdir+bench
design/vita_tx_pkg.sv
design/vita_tx_deframer.sv
design/vita_tx_control.sv
design/dsp_core_tx.sv
design/gen_context_pkt.sv
design/vita_tx_chain.sv
bench/tb_vita_tx_chain.sv

// File: run_sim.sh
#!/bin/sh
# build and run the testbench with Verilator, pass only if the log says so
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -Mdir obj_dir -o sim_vita_tx \
   --top-module tb_vita_tx_chain -f vlog.f > build.log 2>&1 \
   || { cat build.log; echo "build failed"; exit 1; }

./obj_dir/sim_vita_tx > sim.log 2>&1
cat sim.log

grep -qF '*** TEST PASSED ***' sim.log && exit 0 || exit 1

// File: bench/tb_vita_tx_tests.svh
// ~~~~~~~~~~~~~~~~~~~~
// bus and stream helpers
task automatic idle_cycles(input int n);
   repeat (n) begin
      @(posedge clk);
      #DRIVE_DLY;
   end
endtask

task automatic write_setting(input logic [7:0] addr, input logic [31:0] data);
   set_addr = addr;
   set_data = data;
   set_stb  = 1'b1;
   idle_cycles(1);
   set_stb  = 1'b0;
endtask

task automatic set_gain(input logic [15:0] g);
   write_setting(`VTX_SR_GAIN, {16'd0, g});
   gain_now = g;
endtask

function automatic vita_tx_pkg::vtx_word_t make_word(input logic sof, input logic eof,
                                                     input logic [31:0] data);
   vita_tx_pkg::vtx_word_t w;
   w.sof  = sof;
   w.eof  = eof;
   w.occ  = 2'b00;
   w.data = data;
   return w;
endfunction

// holds the word until tx_ready_o is seen before an edge
task automatic put_word(input vita_tx_pkg::vtx_word_t w);
   tx_data  = w;
   tx_valid = 1'b1;
   @(negedge clk);
   while (!tx_ready) @(negedge clk);
   idle_cycles(1);
endtask

task automatic queue_sample(input logic [31:0] s);
   pkt_q.push_back(s);
   exp_q.push_back({scaled_value(s[31:16], gain_now), scaled_value(s[15:0], gain_now)});
endtask

// hdr_len of 0 means the true length
task automatic send_packet(input logic has_time, input logic eob, input logic [63:0] ts,
                           input int hdr_len);
   logic [31:0] hdr;
   int          len;
   len = (hdr_len > 0) ? hdr_len : 1 + (has_time ? 2 : 0) + pkt_q.size();
   hdr = '0;
   hdr[`VTX_HDR_HAS_TIME] = has_time;
   hdr[`VTX_HDR_EOB] = eob;
   hdr[`VTX_HDR_LEN_MSB:`VTX_HDR_LEN_LSB] = len[15:0];
   put_word(make_word(1'b1, 1'b0, hdr));
   if (has_time) begin
      put_word(make_word(1'b0, 1'b0, ts[63:32]));
      put_word(make_word(1'b0, 1'b0, ts[31:0]));
   end
   for (int i = 0; i < pkt_q.size(); i++)
      put_word(make_word(1'b0, i == pkt_q.size() - 1, pkt_q[i]));
   tx_valid = 1'b0;
   pkt_q.delete();
endtask

task automatic wait_dac(input int n, input int limit);
   int waited;
   waited = 0;
   while (dac_q.size() < n && waited < limit) begin
      idle_cycles(1);
      waited++;
   end
   if (dac_q.size() < n)
      report_failure($sformatf("only %0d of %0d DAC samples within %0d cycles",
                               dac_q.size(), n, limit));
endtask

task automatic wait_err_words(input int n, input int limit);
   int waited;
   waited = 0;
   while (err_q.size() < n && waited < limit) begin
      idle_cycles(1);
      waited++;
   end
   if (err_q.size() < n)
      report_failure($sformatf("error packet incomplete, %0d of %0d words", err_q.size(), n));
endtask

task automatic compare_dac();
   logic [31:0] got;
   logic [31:0] want;
   while (exp_q.size() > 0) begin
      want = exp_q.pop_front();
      if (dac_q.size() == 0) begin
         report_failure("DAC output ended before all expected samples");
         exp_q.delete();
      end else begin
         got = dac_q.pop_front();
         check_value("dac_a_o", got[31:16], want[31:16]);
         check_value("dac_b_o", got[15:0], want[15:0]);
      end
   end
   if (dac_q.size() != 0) report_failure("DAC produced more samples than were sent");
   dac_q.delete();
   dac_time_q.delete();
endtask

task automatic check_error_packet(input logic [31:0] code, input logic [63:0] min_time);
   vita_tx_pkg::vtx_word_t w [5];
   logic [63:0]            t;
   if (err_q.size() != `VTX_ERR_PKT_LEN) begin
      report_failure($sformatf("expected one 5 word error packet, saw %0d words", err_q.size()));
   end else begin
      foreach (w[i]) w[i] = err_q.pop_front();
      check_value("err_data_o.sof", w[0].sof, 1'b1);
      check_value("err_data_o.eof", {w[3].eof, w[4].eof}, 2'b01);
      check_value("err_data_o length", w[0].data[`VTX_HDR_LEN_MSB:`VTX_HDR_LEN_LSB], 16'd5);
      check_value("err_data_o stream id", w[1].data, stream_id);
      check_value("err_data_o code", w[2].data, code);
      t = {w[3].data, w[4].data};
      if (t < min_time)
         report_failure($sformatf("error err_data_o time: got 0x%0h, expected at least 0x%0h",
                                  t, min_time));
   end
   err_q.delete();
endtask

task automatic report_test(input string name, input int errs_before);
   n_tests++;
   $display("test %-20s %s", name, (n_errors == errs_before) ? "ok" : "failed");
endtask

// ~~~~~~~~~~~~~~~~~~~~
// directed tests
task automatic untimed_burst();
   int errs;
   errs = n_errors;
   write_setting(`VTX_SR_RATE, 32'd0);
   set_gain(16'd16384);   // unity
   for (int i = 0; i < 16; i++) queue_sample(next_random());
   send_packet(1'b0, 1'b1, 64'd0, 0);
   wait_dac(16, 100);
   idle_cycles(4);
   compare_dac();
   check_value("run_o", run, 1'b0);
   check_value("underrun_o pulses", underrun_cnt, 0);
   check_value("err_valid_o words", err_q.size(), 0);
   report_test("untimed_burst", errs);
endtask

task automatic gain_and_saturation();
   logic [31:0] edge_vals [6];
   logic [15:0] gains [2];
   int          errs;
   edge_vals = '{32'h7fff_8000, 32'h0000_0000, 32'h8000_7fff,
                 32'h03e8_fc18, 32'hffff_0001, 32'h4000_c000};
   gains = '{16'h7fff, 16'h2000};   // just under 2.0, then 0.5
   errs = n_errors;
   foreach (gains[k]) begin
      set_gain(gains[k]);
      foreach (edge_vals[i]) queue_sample(edge_vals[i]);
      queue_sample(next_random());
      send_packet(1'b0, 1'b1, 64'd0, 0);
      wait_dac(7, 100);
      compare_dac();
   end
   set_gain(16'd16384);
   report_test("gain_and_saturation", errs);
endtask

task automatic timed_start();
   logic [63:0] ts;
   int          errs;
   errs = n_errors;
   write_setting(`VTX_SR_RATE, 32'd3);
   for (int i = 0; i < 8; i++) queue_sample(next_random());
   ts = vita_time + 64'd200;
   send_packet(1'b1, 1'b1, ts, 0);
   wait_dac(8, 100);
   if (dac_time_q.size() >= 8) begin
      check_value("dac_stb_o time", dac_time_q[0], ts + 64'd2);
      for (int i = 1; i < 8; i++)
         check_value("dac_stb_o spacing", dac_time_q[i] - dac_time_q[i - 1], 64'd4);
   end
   compare_dac();
   report_test("timed_start", errs);
endtask

task automatic late_burst();
   logic [63:0] ts;
   int          errs;
   errs = n_errors;
   stream_id = 32'h5a17_0c3e;
   write_setting(`VTX_SR_STREAMID, stream_id);
   write_setting(`VTX_SR_RATE, 32'd0);
   ts = vita_time - 64'd20;
   for (int i = 0; i < 4; i++) pkt_q.push_back(next_random());
   send_packet(1'b1, 1'b1, ts, 0);
   wait_err_words(5, 50);
   idle_cycles(10);
   check_value("dac_stb_o count", dac_q.size(), 0);
   check_error_packet(vita_tx_pkg::ERR_LATE, ts);
   for (int i = 0; i < 6; i++) queue_sample(next_random());
   send_packet(1'b0, 1'b1, 64'd0, 0);
   wait_dac(6, 100);
   compare_dac();
   report_test("late_burst", errs);
endtask

task automatic underrun_recovery();
   logic [63:0] t_start;
   int          errs;
   errs = n_errors;
   underrun_cnt = 0;
   err_ready = 1'b0;
   t_start = vita_time;
   for (int i = 0; i < 5; i++) queue_sample(next_random());
   send_packet(1'b0, 1'b0, 64'd0, 0);   // no eob, then a gap
   wait_dac(5, 50);
   compare_dac();
   idle_cycles(30);
   check_value("err_valid_o", err_valid, 1'b1);
   check_value("err_data_o.sof", err_data.sof, 1'b1);   // first word held
   err_ready = 1'b1;
   wait_err_words(5, 20);
   check_error_packet(vita_tx_pkg::ERR_UNDERRUN, t_start);
   for (int i = 0; i < 4; i++) pkt_q.push_back(next_random());
   send_packet(1'b0, 1'b1, 64'd0, 0);   // dropped
   idle_cycles(8);
   check_value("dac_stb_o count", dac_q.size(), 0);
   for (int i = 0; i < 6; i++) queue_sample(next_random());
   send_packet(1'b0, 1'b1, 64'd0, 0);
   wait_dac(6, 100);
   compare_dac();
   check_value("underrun_o pulses", underrun_cnt, 1);
   report_test("underrun_recovery", errs);
endtask

task automatic malformed_length();
   int errs;
   errs = n_errors;
   underrun_cnt = 0;
   for (int i = 0; i < 4; i++) pkt_q.push_back(next_random());
   send_packet(1'b0, 1'b1, 64'd0, 2);    // eof comes late
   pkt_q.push_back(next_random());
   send_packet(1'b0, 1'b1, 64'd0, 10);   // eof comes early
   idle_cycles(8);
   check_value("dac_stb_o count", dac_q.size(), 0);
   check_value("run_o", run, 1'b0);
   for (int i = 0; i < 6; i++) queue_sample(next_random());
   send_packet(1'b0, 1'b1, 64'd0, 0);
   wait_dac(6, 100);
   compare_dac();
   check_value("underrun_o pulses", underrun_cnt, 0);
   report_test("malformed_length", errs);
endtask

// File: bench/tb_vita_tx_chain.sv
`timescale 1ns/1ps
`include "vita_tx_defines.svh"

module tb_vita_tx_chain;

   localparam int CLK_HALF     = 10;
   localparam int DRIVE_DLY    = 1;   // after rising edge
   localparam int RESET_CYCLES = 5;

   // ~~~~~~~~~~~~~~~~~~~~
   // run limit
   localparam int TEST_WORDS     = 90;    // host words over all test packets
   localparam int MAX_RATE       = 3;
   localparam int GAP_CYCLES     = 380;   // timed start, error hold, idle gaps
   localparam int TIMEOUT_CYCLES = 2 * (TEST_WORDS * (MAX_RATE + 1) + GAP_CYCLES);

   logic                   clk;
   logic                   rst_n;
   logic                   set_stb;
   logic [7:0]             set_addr;
   logic [31:0]            set_data;
   logic [63:0]            vita_time = '0;
   vita_tx_pkg::vtx_word_t tx_data;
   logic                   tx_valid;
   logic                   tx_ready;
   vita_tx_pkg::vtx_word_t err_data;
   logic                   err_valid;
   logic                   err_ready;
   logic [15:0]            dac_a;
   logic [15:0]            dac_b;
   logic                   dac_stb;
   logic                   run;
   logic                   underrun;

   int unsigned            cycle_cnt = 0;
   logic [31:0]            lcg_state;
   int                     n_tests;
   int                     n_checks;
   int                     n_errors;
   int                     underrun_cnt;
   logic [15:0]            gain_now;    // gain the DUT holds
   logic [31:0]            stream_id;

   logic [31:0]            pkt_q[$];    // payload of the next packet
   logic [31:0]            exp_q[$];    // expected {a, b}
   logic [31:0]            dac_q[$];
   logic [63:0]            dac_time_q[$];
   vita_tx_pkg::vtx_word_t err_q[$];

   vita_tx_chain dut0 (
      .clk(clk), .rst_n_i(rst_n),
      .set_stb_i(set_stb), .set_addr_i(set_addr), .set_data_i(set_data),
      .vita_time_i(vita_time),
      .tx_data_i(tx_data), .tx_valid_i(tx_valid), .tx_ready_o(tx_ready),
      .err_data_o(err_data), .err_valid_o(err_valid), .err_ready_i(err_ready),
      .dac_a_o(dac_a), .dac_b_o(dac_b), .dac_stb_o(dac_stb),
      .run_o(run), .underrun_o(underrun)
   );

   initial begin
      clk = 1'b0;
      forever #CLK_HALF clk = ~clk;
   end

   always @(posedge clk) begin : time_counter
      logic [63:0] time_next;
      time_next = rst_n ? vita_time + 64'd1 : 64'd0;   // rst_n sampled at the edge
      #DRIVE_DLY;
      vita_time = time_next;
   end

   always @(posedge clk) cycle_cnt <= cycle_cnt + 1;

   // ~~~~~~~~~~~~~~~~~~~~
   // output monitors, mid cycle
   always @(negedge clk) begin
      if (rst_n) begin
         if (dac_stb) begin
            dac_q.push_back({dac_a, dac_b});
            dac_time_q.push_back(vita_time);
         end
         if (err_valid && err_ready) err_q.push_back(err_data);
         if (underrun) underrun_cnt++;
      end
   end

   function automatic logic [31:0] next_random();
      lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
      return lcg_state;
   endfunction

   // q2.14 gain, floor shift, clamp to signed 16
   function automatic logic [15:0] scaled_value(input logic [15:0] x, input logic [15:0] g);
      longint p;
      p = longint'($signed(x)) * longint'($signed(g));
      p = p >>> 14;
      if (p > 32767) p = 32767;
      else if (p < -32768) p = -32768;
      return p[15:0];
   endfunction

   task automatic check_value(input string name, input logic [63:0] got,
                              input logic [63:0] want);
      n_checks++;
      if (got !== want) begin
         $display("error %s: got 0x%0h, expected 0x%0h", name, got, want);
         n_errors++;
      end
   endtask

   task automatic report_failure(input string msg);
      $display("%s", msg);
      n_errors++;
   endtask

   `include "tb_vita_tx_tests.svh"

   initial begin : watchdog
      wait (cycle_cnt >= TIMEOUT_CYCLES);
      $display("timeout: tests still running after %0d cycles", TIMEOUT_CYCLES);
      $display("*** TEST FAILED ***");
      $finish;
   end

   initial begin
      rst_n        = 1'b0;
      set_stb      = 1'b0;
      set_addr     = '0;
      set_data     = '0;
      tx_data      = '0;
      tx_valid     = 1'b0;
      err_ready    = 1'b1;
      lcg_state    = 32'd87;
      n_tests      = 0;
      n_checks     = 0;
      n_errors     = 0;
      underrun_cnt = 0;
      gain_now     = 16'd16384;
      stream_id    = '0;
      repeat (RESET_CYCLES) @(posedge clk);
      #DRIVE_DLY rst_n = 1'b1;
      untimed_burst();
      gain_and_saturation();
      timed_start();
      late_burst();
      underrun_recovery();
      malformed_length();
      idle_cycles(5);
      $display("tests %0d, checks %0d, errors %0d", n_tests, n_checks, n_errors);
      if (n_errors == 0) begin
         $display("*** TEST PASSED ***");
      end else begin
         $display("*** TEST FAILED ***");
      end
      $finish;
   end

endmodule

// File: design/vita_tx_chain.sv
`timescale 1ns/1ps

module vita_tx_chain (
   input  logic                   clk,
   input  logic                   rst_n_i,
   input  logic                   set_stb_i,
   input  logic [7:0]             set_addr_i,
   input  logic [31:0]            set_data_i,
   input  logic [63:0]            vita_time_i,
   input  vita_tx_pkg::vtx_word_t tx_data_i,
   input  logic                   tx_valid_i,
   output logic                   tx_ready_o,
   output vita_tx_pkg::vtx_word_t err_data_o,
   output logic                   err_valid_o,
   input  logic                   err_ready_i,
   output logic [15:0]            dac_a_o,
   output logic [15:0]            dac_b_o,
   output logic                   dac_stb_o,
   output logic                   run_o,
   output logic                   underrun_o
);

   vita_tx_pkg::vtx_sample_t    sample;
   logic                        sample_valid;
   logic                        sample_ready;
   logic [31:0]                 dsp_sample;
   logic                        strobe;
   logic                        err_stb;
   vita_tx_pkg::vtx_err_event_t err_event;

   vita_tx_deframer vita_tx_deframer (
      .clk(clk), .rst_n_i(rst_n_i),
      .set_stb_i(set_stb_i), .set_addr_i(set_addr_i), .set_data_i(set_data_i),
      .tx_data_i(tx_data_i), .tx_valid_i(tx_valid_i), .tx_ready_o(tx_ready_o),
      .sample_o(sample), .sample_valid_o(sample_valid), .sample_ready_i(sample_ready)
   );

   vita_tx_control vita_tx_control (
      .clk(clk), .rst_n_i(rst_n_i),
      .set_stb_i(set_stb_i), .set_addr_i(set_addr_i), .set_data_i(set_data_i),
      .vita_time_i(vita_time_i),
      .sample_i(sample), .sample_valid_i(sample_valid), .sample_ready_o(sample_ready),
      .sample_o(dsp_sample), .strobe_o(strobe), .run_o(run_o), .underrun_o(underrun_o),
      .err_stb_o(err_stb), .err_event_o(err_event)
   );

   dsp_core_tx dsp_core_tx (
      .clk(clk), .rst_n_i(rst_n_i),
      .set_stb_i(set_stb_i), .set_addr_i(set_addr_i), .set_data_i(set_data_i),
      .sample_i(dsp_sample), .strobe_i(strobe), .run_i(run_o),
      .dac_a_o(dac_a_o), .dac_b_o(dac_b_o), .dac_stb_o(dac_stb_o)
   );

   gen_context_pkt gen_tx_err_pkt (
      .clk(clk), .rst_n_i(rst_n_i),
      .set_stb_i(set_stb_i), .set_addr_i(set_addr_i), .set_data_i(set_data_i),
      .err_stb_i(err_stb), .err_event_i(err_event),
      .err_data_o(err_data_o), .err_valid_o(err_valid_o), .err_ready_i(err_ready_i)
   );

endmodule

// File: design/gen_context_pkt.sv
`timescale 1ns/1ps
`include "vita_tx_defines.svh"

module gen_context_pkt (
   input  logic                        clk,
   input  logic                        rst_n_i,
   input  logic                        set_stb_i,
   input  logic [7:0]                  set_addr_i,
   input  logic [31:0]                 set_data_i,
   input  logic                        err_stb_i,
   input  vita_tx_pkg::vtx_err_event_t err_event_i,
   output vita_tx_pkg::vtx_word_t      err_data_o,
   output logic                        err_valid_o,
   input  logic                        err_ready_i
);

   logic [31:0]                 streamid_q;
   vita_tx_pkg::vtx_err_event_t ev_q;
   logic                        busy_q;
   logic [2:0]                  word_cnt_q;

   logic                        clear;
   logic                        last_word;

   assign clear       = set_stb_i && (set_addr_i == `VTX_SR_CLEAR);
   assign last_word   = word_cnt_q == 3'(`VTX_ERR_PKT_LEN - 1);
   assign err_valid_o = busy_q;

   always_ff @(posedge clk or negedge rst_n_i) begin
      if (!rst_n_i) begin
         streamid_q <= '0;
      end else if (set_stb_i && (set_addr_i == `VTX_SR_STREAMID)) begin
         streamid_q <= set_data_i;
      end
   end

   always_ff @(posedge clk or negedge rst_n_i) begin
      if (!rst_n_i) begin
         busy_q     <= 1'b0;
         word_cnt_q <= '0;
      end else if (clear) begin
         busy_q     <= 1'b0;   // abort packet
         word_cnt_q <= '0;
      end else if (!busy_q) begin
         busy_q <= err_stb_i;
      end else if (err_ready_i) begin
         if (last_word) begin
            busy_q     <= 1'b0;
            word_cnt_q <= '0;
         end else begin
            word_cnt_q <= word_cnt_q + 3'd1;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (!busy_q && err_stb_i) ev_q <= err_event_i;   // events while busy are lost
   end

   always_comb begin
      err_data_o.sof = word_cnt_q == 3'd0;
      err_data_o.eof = last_word;
      err_data_o.occ = 2'b00;
      err_data_o.data = '0;
      case (word_cnt_q)
         3'd0: err_data_o.data[`VTX_HDR_LEN_MSB:`VTX_HDR_LEN_LSB] = 16'(`VTX_ERR_PKT_LEN);
         3'd1: err_data_o.data = streamid_q;
         3'd2: err_data_o.data = ev_q.code;
         3'd3: err_data_o.data = ev_q.ev_time[63:32];
         default: err_data_o.data = ev_q.ev_time[31:0];
      endcase
   end

   a_cnt_range: assert property (@(posedge clk) disable iff (!rst_n_i)
      word_cnt_q <= 3'(`VTX_ERR_PKT_LEN - 1));

endmodule

// File: design/dsp_core_tx.sv
`timescale 1ns/1ps
`include "vita_tx_defines.svh"

module dsp_core_tx (
   input  logic        clk,
   input  logic        rst_n_i,
   input  logic        set_stb_i,
   input  logic [7:0]  set_addr_i,
   input  logic [31:0] set_data_i,
   input  logic [31:0] sample_i,
   input  logic        strobe_i,
   input  logic        run_i,
   output logic [15:0] dac_a_o,
   output logic [15:0] dac_b_o,
   output logic        dac_stb_o
);

   logic signed [15:0] gain_q;
   logic signed [31:0] prod_i_q;
   logic signed [31:0] prod_q_q;
   logic               stg1_vld_q;

   function automatic logic [15:0] scale_sat(input logic [31:0] prod);
      logic [17:0] shifted;
      shifted = prod[31:14];   // arithmetic >>> 14
      if (shifted[17:15] == 3'b000 || shifted[17:15] == 3'b111) begin
         return shifted[15:0];
      end
      return shifted[17] ? 16'h8000 : 16'h7fff;
   endfunction

   always_ff @(posedge clk or negedge rst_n_i) begin
      if (!rst_n_i) begin
         gain_q <= 16'sd16384;   // unity
      end else if (set_stb_i && (set_addr_i == `VTX_SR_GAIN)) begin
         gain_q <= set_data_i[15:0];
      end
   end

   // stage 1 multiply
   always_ff @(posedge clk) begin
      if (strobe_i && run_i) begin
         prod_i_q <= $signed(sample_i[31:16]) * gain_q;
         prod_q_q <= $signed(sample_i[15:0]) * gain_q;
      end
   end

   // stage 2 shift and saturate
   always_ff @(posedge clk or negedge rst_n_i) begin
      if (!rst_n_i) begin
         stg1_vld_q <= 1'b0;
         dac_stb_o  <= 1'b0;
         dac_a_o    <= '0;
         dac_b_o    <= '0;
      end else begin
         stg1_vld_q <= strobe_i && run_i;
         dac_stb_o  <= stg1_vld_q;
         if (stg1_vld_q) begin
            dac_a_o <= scale_sat(prod_i_q);
            dac_b_o <= scale_sat(prod_q_q);
         end
      end
   end

endmodule

// File: design/vita_tx_control.sv
`timescale 1ns/1ps
`include "vita_tx_defines.svh"

module vita_tx_control (
   input  logic                        clk,
   input  logic                        rst_n_i,
   input  logic                        set_stb_i,
   input  logic [7:0]                  set_addr_i,
   input  logic [31:0]                 set_data_i,
   input  logic [63:0]                 vita_time_i,
   input  vita_tx_pkg::vtx_sample_t    sample_i,
   input  logic                        sample_valid_i,
   output logic                        sample_ready_o,
   output logic [31:0]                 sample_o,
   output logic                        strobe_o,
   output logic                        run_o,
   output logic                        underrun_o,
   output logic                        err_stb_o,
   output vita_tx_pkg::vtx_err_event_t err_event_o
);

   vita_tx_pkg::vtx_ctrl_state_e state_q;
   logic [15:0]                  rate_q;
   logic [15:0]                  strb_cnt_q;

   logic                         clear;
   logic                         tick;
   logic                         late_head;
   logic                         time_hit;
   logic                         underrun;

   assign clear     = set_stb_i && (set_addr_i == `VTX_SR_CLEAR);
   assign tick      = (state_q == vita_tx_pkg::ST_RUN) && (strb_cnt_q == 16'd0);
   assign late_head = (state_q == vita_tx_pkg::ST_IDLE) && sample_valid_i &&
                      sample_i.has_time && (sample_i.timestamp < vita_time_i);
   // state is run in the cycle where the time matches
   assign time_hit  = sample_i.timestamp <= vita_time_i + 64'd1;
   assign underrun  = tick && !sample_valid_i;

   assign strobe_o       = tick && sample_valid_i;
   assign run_o          = state_q == vita_tx_pkg::ST_RUN;
   assign sample_o       = sample_i.sample;
   assign sample_ready_o = strobe_o || (state_q == vita_tx_pkg::ST_DROP);

   always_ff @(posedge clk or negedge rst_n_i) begin
      if (!rst_n_i) begin
         rate_q <= '0;
      end else if (set_stb_i && (set_addr_i == `VTX_SR_RATE)) begin
         rate_q <= set_data_i[15:0];
      end
   end

   always_ff @(posedge clk or negedge rst_n_i) begin
      if (!rst_n_i) begin
         strb_cnt_q <= '0;
      end else if (state_q != vita_tx_pkg::ST_RUN) begin
         strb_cnt_q <= '0;   // first run cycle strobes
      end else if (strb_cnt_q == 16'd0) begin
         strb_cnt_q <= rate_q;
      end else begin
         strb_cnt_q <= strb_cnt_q - 16'd1;
      end
   end

   // ~~~~~~~~~~~~~~~~~~~~
   // burst state machine
   always_ff @(posedge clk or negedge rst_n_i) begin
      if (!rst_n_i) begin
         state_q <= vita_tx_pkg::ST_IDLE;
      end else if (clear) begin
         state_q <= vita_tx_pkg::ST_IDLE;
      end else begin
         case (state_q)
            vita_tx_pkg::ST_IDLE: begin
               if (sample_valid_i) begin
                  if (!sample_i.has_time) state_q <= vita_tx_pkg::ST_RUN;
                  else if (late_head) state_q <= vita_tx_pkg::ST_DROP;
                  else state_q <= vita_tx_pkg::ST_WAIT_TIME;
               end
            end
            vita_tx_pkg::ST_WAIT_TIME: begin
               if (time_hit) state_q <= vita_tx_pkg::ST_RUN;
            end
            vita_tx_pkg::ST_RUN: begin
               if (underrun) state_q <= vita_tx_pkg::ST_DROP;
               else if (strobe_o && sample_i.eob) state_q <= vita_tx_pkg::ST_IDLE;
            end
            default: begin   // drop through eob
               if (sample_valid_i && sample_i.eob) state_q <= vita_tx_pkg::ST_IDLE;
            end
         endcase
      end
   end

   always_ff @(posedge clk or negedge rst_n_i) begin
      if (!rst_n_i) begin
         err_stb_o  <= 1'b0;
         underrun_o <= 1'b0;
      end else if (clear) begin
         err_stb_o  <= 1'b0;
         underrun_o <= 1'b0;
      end else begin
         err_stb_o  <= late_head || underrun;
         underrun_o <= underrun;
      end
   end

   always_ff @(posedge clk) begin
      if (late_head || underrun) begin
         err_event_o.code    <= underrun ? vita_tx_pkg::ERR_UNDERRUN : vita_tx_pkg::ERR_LATE;
         err_event_o.ev_time <= vita_time_i;
      end
   end

   a_strobe_in_run: assert property (@(posedge clk) disable iff (!rst_n_i)
      strobe_o |-> state_q == vita_tx_pkg::ST_RUN);

   a_err_pulse: assert property (@(posedge clk) disable iff (!rst_n_i)
      err_stb_o |=> !err_stb_o);

endmodule

// File: design/vita_tx_deframer.sv
`timescale 1ns/1ps
`include "vita_tx_defines.svh"

module vita_tx_deframer (
   input  logic                     clk,
   input  logic                     rst_n_i,
   input  logic                     set_stb_i,
   input  logic [7:0]               set_addr_i,
   input  logic [31:0]              set_data_i,
   input  vita_tx_pkg::vtx_word_t   tx_data_i,
   input  logic                     tx_valid_i,
   output logic                     tx_ready_o,
   output vita_tx_pkg::vtx_sample_t sample_o,
   output logic                     sample_valid_o,
   input  logic                     sample_ready_i
);

   typedef enum logic [2:0] {
      DF_HDR,
      DF_TIME_HI,
      DF_TIME_LO,
      DF_PAYLOAD,
      DF_DROP
   } df_state_e;

   df_state_e                state_q;
   logic [15:0]              len_q;
   logic [15:0]              cnt_q;
   logic                     has_time_q;
   logic                     eob_q;
   logic                     first_q;
   logic [63:0]              time_q;
   vita_tx_pkg::vtx_sample_t out_q;
   logic                     out_valid_q;

   logic                     clear;
   logic                     accept;
   logic [15:0]              word_num;
   logic [15:0]              len_now;
   logic                     len_err;
   logic                     emit;

   assign clear      = set_stb_i && (set_addr_i == `VTX_SR_CLEAR);
   assign tx_ready_o = !out_valid_q || sample_ready_i;
   assign accept     = tx_valid_i && tx_ready_o;
   assign word_num   = cnt_q + 16'd1;   // 1-based index of current word
   assign len_now    = (state_q == DF_HDR) ?
                       tx_data_i.data[`VTX_HDR_LEN_MSB:`VTX_HDR_LEN_LSB] : len_q;
   assign len_err    = tx_data_i.eof != (word_num == len_now);
   assign emit       = accept && (state_q == DF_PAYLOAD) && !len_err;

   // ~~~~~~~~~~~~~~~~~~~~
   // packet parser
   always_ff @(posedge clk or negedge rst_n_i) begin
      if (!rst_n_i) begin
         state_q <= DF_HDR;
         cnt_q   <= '0;
         first_q <= 1'b0;
      end else if (clear) begin
         state_q <= DF_HDR;
         cnt_q   <= '0;
         first_q <= 1'b0;
      end else if (accept) begin
         if (state_q == DF_HDR) first_q <= 1'b1;
         else if (emit) first_q <= 1'b0;
         if (tx_data_i.eof) begin
            state_q <= DF_HDR;
            cnt_q   <= '0;
         end else if (len_err) begin
            state_q <= DF_DROP;   // skip to eof
         end else begin
            cnt_q <= word_num;
            case (state_q)
               DF_HDR:     state_q <= tx_data_i.data[`VTX_HDR_HAS_TIME] ? DF_TIME_HI : DF_PAYLOAD;
               DF_TIME_HI: state_q <= DF_TIME_LO;
               DF_TIME_LO: state_q <= DF_PAYLOAD;
               default:    state_q <= state_q;
            endcase
         end
      end
   end

   always_ff @(posedge clk) begin
      if (accept) begin
         case (state_q)
            DF_HDR: begin
               len_q      <= tx_data_i.data[`VTX_HDR_LEN_MSB:`VTX_HDR_LEN_LSB];
               has_time_q <= tx_data_i.data[`VTX_HDR_HAS_TIME];
               eob_q      <= tx_data_i.data[`VTX_HDR_EOB];
            end
            DF_TIME_HI: time_q[63:32] <= tx_data_i.data;
            DF_TIME_LO: time_q[31:0]  <= tx_data_i.data;
            default: ;
         endcase
      end
   end

   // ~~~~~~~~~~~~~~~~~~~~
   // output register
   always_ff @(posedge clk or negedge rst_n_i) begin
      if (!rst_n_i) begin
         out_valid_q <= 1'b0;
      end else if (clear) begin
         out_valid_q <= 1'b0;
      end else if (emit) begin
         out_valid_q <= 1'b1;
      end else if (sample_ready_i) begin
         out_valid_q <= 1'b0;
      end
   end

   always_ff @(posedge clk) begin
      if (emit) begin
         out_q.sample    <= tx_data_i.data;
         out_q.timestamp <= time_q;
         out_q.has_time  <= has_time_q && first_q;   // head sample only
         out_q.eob       <= eob_q && tx_data_i.eof;
         out_q.sob       <= first_q;
         out_q.spare     <= 1'b0;
      end
   end

   assign sample_o       = out_q;
   assign sample_valid_o = out_valid_q;

   a_out_stable: assert property (@(posedge clk) disable iff (!rst_n_i)
      sample_valid_o && !sample_ready_i |=> $stable(sample_o));

endmodule

// File: design/vita_tx_pkg.sv
package vita_tx_pkg;

   // one host word, 36 bits
   typedef struct packed {
      logic        sof;
      logic        eof;
      logic [1:0]  occ;        // always zero here
      logic [31:0] data;
   } vtx_word_t;

   // tagged sample, 100 bits
   typedef struct packed {
      logic        spare;
      logic        sob;
      logic        eob;
      logic        has_time;
      logic [63:0] timestamp;
      logic [31:0] sample;     // i high, q low
   } vtx_sample_t;

   typedef enum logic [31:0] {
      ERR_NONE     = 32'd0,
      ERR_UNDERRUN = 32'd2,
      ERR_LATE     = 32'd8
   } vtx_err_code_e;

   typedef struct packed {
      vtx_err_code_e code;
      logic [63:0]   ev_time;
   } vtx_err_event_t;

   typedef enum logic [1:0] {
      ST_IDLE,
      ST_WAIT_TIME,
      ST_RUN,
      ST_DROP
   } vtx_ctrl_state_e;

endpackage

// File: design/vita_tx_defines.svh
`ifndef VITA_TX_DEFINES_SVH
`define VITA_TX_DEFINES_SVH

// ~~~~~~~~~~~~~~~~~~~~
// settings bus map
`define VTX_SR_RATE       8'd0   // strobe period minus one
`define VTX_SR_GAIN       8'd1   // q2.14, 16384 is unity
`define VTX_SR_STREAMID   8'd2
`define VTX_SR_CLEAR      8'd3   // any write pulses clear

// ~~~~~~~~~~~~~~~~~~~~
// host packet header
`define VTX_HDR_HAS_TIME  31
`define VTX_HDR_EOB       30
`define VTX_HDR_LEN_MSB   15
`define VTX_HDR_LEN_LSB   0     // length in words, header included

`define VTX_ERR_PKT_LEN   5

`endif
